//--- testbench/core_golden.txt
# D op dest src_a src_b imm gap : op 0 add 1 sub 2 and 3 or 4 xor 5 li, gap 1 allows idle cycles
# C dest value : expected commit in program order, all fields hex
# load immediates into every register
D 5 0 0 0 1234 1
C 0 1234
D 5 1 0 0 00ff 1
C 1 00ff
D 5 2 0 0 f0f0 1
C 2 f0f0
D 5 3 0 0 8001 1
C 3 8001
D 5 4 0 0 0f0f 1
C 4 0f0f
D 5 5 0 0 7fff 1
C 5 7fff
D 5 6 0 0 0003 1
C 6 0003
D 5 7 0 0 a5a5 1
C 7 a5a5
# one of each alu op on the loaded registers, add wraps to zero
D 0 0 5 3 0000 1
C 0 0000
D 1 1 6 7 0000 1
C 1 5a5e
D 2 2 2 7 0000 1
C 2 a0a0
D 3 3 4 2 0000 1
C 3 afaf
D 4 4 7 1 0000 1
C 4 fffb
# back-to-back dependent chain on r5, longer than the rob
D 0 5 5 6 0000 1
C 5 8002
D 0 5 5 5 0000 0
C 5 0004
D 1 5 5 6 0000 0
C 5 0001
D 4 5 5 7 0000 0
C 5 a5a4
D 2 5 5 3 0000 0
C 5 a5a4
D 3 5 5 1 0000 0
C 5 fffe
D 0 5 5 4 0000 0
C 5 fff9
D 1 5 0 5 0000 0
C 5 0007
D 0 5 5 5 0000 0
C 5 000e
# independent li behind the chain, then a reader of both results
D 5 6 0 0 0bad 0
C 6 0bad
D 0 7 5 6 0000 1
C 7 0bbb

//--- ooo_core.f
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/rename_map.sv
rtl/phys_regfile.sv
rtl/issue_station.sv
rtl/alu_unit.sv
rtl/reorder_buffer.sv
rtl/core_top.sv
testbench/tb_core.sv

//--- run_sim.sh
#!/bin/sh
# build the core and its testbench with verilator, then run it
# the run fails when the simulation exits badly or logs the failure line
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir

verilator --binary --assert -Wno-fatal --top-module tb_core -f ooo_core.f -o Vtb_core

if ! ./obj_dir/Vtb_core > "$LOG" 2>&1; then
	cat "$LOG"
	echo "FAIL: simulation exited with an error, see $LOG"
	exit 1
fi
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
	echo "FAIL: see $LOG"
	exit 1
fi
echo "PASS"

//--- testbench/tb_core.sv
//////////////////////////////////////////////////////////////////////
// testbench for core_top that replays the golden op stream on the
// dispatch port and checks every commit against the golden sequence
// run from the project root so the golden file path resolves
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_core import core_pkg::*, isa_pkg::*; ();

	//////////////////////////////////////////////////////////////////////
	// dut side
	logic      clock = 1'b0;
	logic      rst_n;
	logic      dispatch_valid;
	opcode_t   op;
	arch_reg_t dest;
	arch_reg_t src_a;
	arch_reg_t src_b;
	word_t     imm;
	logic      dispatch_ready;
	logic      commit_valid;
	arch_reg_t commit_dest;
	word_t     commit_value;

	// golden stream with one entry per D line and per C line
	opcode_t   g_op      [$];
	arch_reg_t g_dest    [$];
	arch_reg_t g_src_a   [$];
	arch_reg_t g_src_b   [$];
	word_t     g_imm     [$];
	logic      g_gap     [$];	// 1 lets idle cycles go in front of the op
	arch_reg_t exp_dest  [$];
	word_t     exp_value [$];

	integer seed         = 19122;
	int     commits_seen = 0;
	int     fail_count   = 0;	// wrong values
	int     error_count  = 0;	// everything else
	logic   loaded       = 1'b0;
	logic   stall_seen   = 1'b0;	// an op had to wait on dispatch_ready

	core_top u_dut (.clock(clock), .rst_n(rst_n), .dispatch_valid(dispatch_valid),
		.op(op), .dest(dest), .src_a(src_a), .src_b(src_b), .imm(imm),
		.dispatch_ready(dispatch_ready), .commit_valid(commit_valid),
		.commit_dest(commit_dest), .commit_value(commit_value));

	always #20 clock = ~clock;	// period 40

	//////////////////////////////////////////////////////////////////////
	// golden file and compare tasks
	task automatic load_golden();
		int    fd;
		int    n;
		int    f [6];
		string line;
		fd = $fopen("testbench/core_golden.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("Error: cannot open testbench/core_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0) begin
					// comment and blank lines match neither format
					if ($sscanf(line, "D %h %h %h %h %h %h",
							f[0], f[1], f[2], f[3], f[4], f[5]) == 6) begin
						g_op.push_back(opcode_t'(f[0][2:0]));
						g_dest.push_back(arch_reg_t'(f[1]));
						g_src_a.push_back(arch_reg_t'(f[2]));
						g_src_b.push_back(arch_reg_t'(f[3]));
						g_imm.push_back(word_t'(f[4]));
						g_gap.push_back(f[5] != 0);
					end else if ($sscanf(line, "C %h %h", f[1], f[4]) == 2) begin
						exp_dest.push_back(arch_reg_t'(f[1]));
						exp_value.push_back(word_t'(f[4]));
					end
				end
			end
			$fclose(fd);
			if (g_op.size() == 0 || g_op.size() != exp_dest.size()) begin
				error_count++;
				$display("Error: golden file holds %0d ops but %0d expected commits",
					g_op.size(), exp_dest.size());
			end
		end
	endtask

	task automatic check_dest(input int idx, input arch_reg_t got, input arch_reg_t exp);
		if (got !== exp) begin
			fail_count++;
			$display("Fail at %0t: commit %0d wrote r%0d, expected r%0d",
				$time, idx, got, exp);
		end
	endtask

	task automatic check_value(input int idx, input word_t got, input word_t exp);
		if (got !== exp) begin
			fail_count++;
			$display("Fail at %0t: commit %0d value %h, expected %h",
				$time, idx, got, exp);
		end
	endtask

	// present op k right after a rising edge and hold it until the core takes it
	task automatic dispatch_op(input int k);
		logic ok;
		dispatch_valid <= 1'b1;
		op             <= g_op[k];
		dest           <= g_dest[k];
		src_a          <= g_src_a[k];
		src_b          <= g_src_b[k];
		imm            <= g_imm[k];
		do begin
			@(negedge clock);
			ok = dispatch_ready;	// settled between edges
			if (!ok) stall_seen = 1'b1;
			@(posedge clock);	// accepted on this edge when ok
		end while (!ok);
	endtask

	//////////////////////////////////////////////////////////////////////
	// commit monitor sampling at the negedge where each pulse is seen once
	always @(negedge clock) begin
		if (rst_n && commit_valid) begin
			if (commits_seen >= exp_dest.size()) begin
				error_count++;
				$display("Error at %0t: extra commit to r%0d beyond the golden sequence",
					$time, commit_dest);
			end else begin
				check_dest(commits_seen, commit_dest, exp_dest[commits_seen]);
				check_value(commits_seen, commit_value, exp_value[commits_seen]);
			end
			commits_seen++;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// main sequence
	initial begin : main
		int gap;
		rst_n          <= 1'b0;
		dispatch_valid <= 1'b0;
		op             <= OP_ADD;
		dest           <= '0;
		src_a          <= '0;
		src_b          <= '0;
		imm            <= '0;
		load_golden();
		loaded = 1'b1;
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;

		// idle core after reset
		repeat (3) begin
			@(negedge clock);
			if (commit_valid) begin
				fail_count++;
				$display("Fail at %0t: commit_valid high before any dispatch", $time);
			end
			if (!dispatch_ready) begin
				fail_count++;
				$display("Fail at %0t: dispatch_ready low on an empty core", $time);
			end
		end

		@(posedge clock);
		for (int k = 0; k < g_op.size(); k++) begin
			gap = g_gap[k] ? ($unsigned($random(seed)) % 4) : 0;	// 0..3 idle cycles
			if (gap > 0) begin
				dispatch_valid <= 1'b0;
				repeat (gap) @(posedge clock);
			end
			dispatch_op(k);
		end
		dispatch_valid <= 1'b0;

		wait (commits_seen >= exp_dest.size());
		repeat (8) @(negedge clock);	// room for a stray extra commit
		if (!stall_seen) begin
			error_count++;
			$display("Error: dispatch_ready never dropped during the back-to-back burst");
		end
		$display("Done: %0d of %0d commits, %0d value mismatches, %0d other errors",
			commits_seen, exp_dest.size(), fail_count, error_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog allows 20 cycles per op plus slack for reset and drain
	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = g_op.size() * 20 + 100;
		repeat (limit) @(posedge clock);
		$display("Error: timeout after %0d cycles with %0d of %0d commits seen",
			limit, commits_seen, exp_dest.size());
		$display("Done: %0d value mismatches, %0d other errors before the timeout",
			fail_count, error_count);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/core_top.sv
//////////////////////////////////////////////////////////////////////
// top of the out-of-order core: rename, regfile, station, alu, rob
// ops enter decoded on dispatch_valid, results leave on commit_valid
//////////////////////////////////////////////////////////////////////
`default_nettype none

module core_top import core_pkg::*, isa_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      dispatch_valid,
	input  opcode_t   op,
	input  arch_reg_t dest,
	input  arch_reg_t src_a,
	input  arch_reg_t src_b,
	input  word_t     imm,
	output logic      dispatch_ready,
	output logic      commit_valid,
	output arch_reg_t commit_dest,
	output word_t     commit_value
);

	phys_tag_t tag_a, tag_b, new_tag, old_tag, commit_free_tag;
	logic      list_empty, rs_full, rob_full, accept, is_li;
	word_t     rf_value_a, rf_value_b, b_value;
	logic      rf_ready_a, rf_ready_b;
	rob_idx_t  rob_tail;
	// station -> alu
	logic      issue_valid;
	opcode_t   issue_op;
	word_t     issue_a, issue_b;
	phys_tag_t issue_tag;
	rob_idx_t  issue_rob_idx;
	// cdb
	logic      cdb_valid;
	phys_tag_t cdb_tag;
	rob_idx_t  cdb_rob_idx;
	word_t     cdb_value;

	assign dispatch_ready = !rob_full && !rs_full && !list_empty;
	assign accept         = dispatch_valid && dispatch_ready;
	assign is_li          = (op == OP_LI);
	assign b_value        = is_li ? imm[IMM_W-1:0] : rf_value_b;	// imm replaces src b

	//////////////////////////////////////////////////////////////////////
	// rename and operand read
	rename_map u_rename (.clock(clock), .rst_n(rst_n), .alloc(accept),
		.src_a(src_a), .src_b(src_b), .dest(dest),
		.free_valid(commit_valid), .free_tag(commit_free_tag),
		.tag_a(tag_a), .tag_b(tag_b), .new_tag(new_tag), .old_tag(old_tag),
		.list_empty(list_empty));

	phys_regfile u_regfile (.clock(clock), .rst_n(rst_n), .tag_a(tag_a), .tag_b(tag_b),
		.alloc(accept), .new_tag(new_tag),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.value_a(rf_value_a), .value_b(rf_value_b), .ready_a(rf_ready_a), .ready_b(rf_ready_b));

	//////////////////////////////////////////////////////////////////////
	// schedule, execute, retire
	issue_station u_station (.clock(clock), .rst_n(rst_n), .load(accept), .op_in(op),
		.a_in(rf_value_a), .b_in(b_value),
		.a_ready(rf_ready_a || is_li), .b_ready(rf_ready_b || is_li),	// li needs no regs
		.tag_a(tag_a), .tag_b(tag_b), .dest_tag(new_tag), .rob_idx(rob_tail),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.full(rs_full), .issue_valid(issue_valid), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag),
		.issue_rob_idx(issue_rob_idx));

	alu_unit u_alu (.clock(clock), .rst_n(rst_n), .issue_valid(issue_valid),
		.issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b),
		.issue_tag(issue_tag), .issue_rob_idx(issue_rob_idx),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_rob_idx(cdb_rob_idx),
		.cdb_value(cdb_value));

	reorder_buffer u_rob (.clock(clock), .rst_n(rst_n), .alloc(accept), .dest(dest),
		.old_tag(old_tag), .cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx),
		.cdb_value(cdb_value), .tail_idx(rob_tail), .full(rob_full),
		.commit_valid(commit_valid), .commit_dest(commit_dest),
		.commit_value(commit_value), .commit_free_tag(commit_free_tag));

endmodule

`default_nettype wire

//--- rtl/reorder_buffer.sv
//////////////////////////////////////////////////////////////////////
// circular reorder buffer, completion from the cdb, commit in order
// commit_valid is high for one cycle per head entry that is done
//////////////////////////////////////////////////////////////////////
`default_nettype none

module reorder_buffer import core_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      alloc,
	input  arch_reg_t dest,
	input  phys_tag_t old_tag,		// mapping replaced by this op
	input  logic      cdb_valid,
	input  rob_idx_t  cdb_rob_idx,
	input  word_t     cdb_value,
	output rob_idx_t  tail_idx,
	output logic      full,
	output logic      commit_valid,
	output arch_reg_t commit_dest,
	output word_t     commit_value,
	output phys_tag_t commit_free_tag
);

	arch_reg_t               dest_q  [ROB_DEPTH];
	phys_tag_t               old_q   [ROB_DEPTH];
	word_t                   value_q [ROB_DEPTH];
	logic [ROB_DEPTH-1:0]    done_q;
	rob_idx_t                head_q;
	rob_idx_t                tail_q;
	logic [$clog2(ROB_DEPTH):0] count_q;	// 0..ROB_DEPTH

	assign tail_idx        = tail_q;	// travels to the station with the op
	assign full            = (count_q == ROB_DEPTH);
	assign commit_valid    = done_q[head_q];
	assign commit_dest     = dest_q[head_q];
	assign commit_value    = value_q[head_q];
	assign commit_free_tag = old_q[head_q];	// back to the free list

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			done_q  <= '0;
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (alloc) begin
				done_q[tail_q] <= 1'b0;
				tail_q         <= tail_q + 1'b1;
			end
			if (cdb_valid) done_q[cdb_rob_idx] <= 1'b1;
			if (commit_valid) begin
				done_q[head_q] <= 1'b0;	// slot is empty again
				head_q         <= head_q + 1'b1;
			end
			case ({alloc, commit_valid})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// entry payload
	always_ff @(posedge clock) begin
		if (alloc) begin
			dest_q[tail_q] <= dest;
			old_q[tail_q]  <= old_tag;
		end
		if (cdb_valid) value_q[cdb_rob_idx] <= cdb_value;
	end

	// a done bit on an empty buffer means the cdb hit a dead slot
	assert property (@(posedge clock) disable iff (!rst_n) commit_valid |-> count_q != '0);

endmodule

`default_nettype wire

//--- rtl/alu_unit.sv
//////////////////////////////////////////////////////////////////////
// single integer alu, one cycle from issue to the registered cdb
// always free, so the station never waits on it
//////////////////////////////////////////////////////////////////////
`default_nettype none

module alu_unit import core_pkg::*, isa_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      issue_valid,
	input  opcode_t   issue_op,
	input  word_t     issue_a,
	input  word_t     issue_b,
	input  phys_tag_t issue_tag,
	input  rob_idx_t  issue_rob_idx,
	output logic      cdb_valid,
	output phys_tag_t cdb_tag,
	output rob_idx_t  cdb_rob_idx,
	output word_t     cdb_value
);

	word_t result;

	always_comb begin
		case (issue_op)
			OP_ADD:  result = issue_a + issue_b;	// wraps at 16 bits
			OP_SUB:  result = issue_a - issue_b;
			OP_AND:  result = issue_a & issue_b;
			OP_OR:   result = issue_a | issue_b;
			OP_XOR:  result = issue_a ^ issue_b;
			OP_LI:   result = issue_b;				// imm rides on operand b
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) cdb_valid <= 1'b0;
		else        cdb_valid <= issue_valid;
	end

	// broadcast payload, only meaningful with cdb_valid
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			cdb_tag     <= issue_tag;
			cdb_rob_idx <= issue_rob_idx;
			cdb_value   <= result;
		end
	end

endmodule

`default_nettype wire

//--- rtl/issue_station.sv
//////////////////////////////////////////////////////////////////////
// reservation station for the single alu
// entries snoop the cdb for missing operands, the oldest ready one issues
//////////////////////////////////////////////////////////////////////
`default_nettype none

module issue_station import core_pkg::*, isa_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      load,
	input  opcode_t   op_in,
	input  word_t     a_in,
	input  word_t     b_in,
	input  logic      a_ready,
	input  logic      b_ready,
	input  phys_tag_t tag_a,
	input  phys_tag_t tag_b,
	input  phys_tag_t dest_tag,
	input  rob_idx_t  rob_idx,
	input  logic      cdb_valid,
	input  phys_tag_t cdb_tag,
	input  word_t     cdb_value,
	output logic      full,
	output logic      issue_valid,
	output opcode_t   issue_op,
	output word_t     issue_a,
	output word_t     issue_b,
	output phys_tag_t issue_tag,
	output rob_idx_t  issue_rob_idx
);

	logic [RS_DEPTH-1:0] valid_q;
	logic [RS_DEPTH-1:0] a_rdy_q;
	logic [RS_DEPTH-1:0] b_rdy_q;
	logic [RS_DEPTH-1:0] older_q [RS_DEPTH];	// bit j set: slot j is older than slot i
	opcode_t             op_q    [RS_DEPTH];
	word_t               a_q     [RS_DEPTH];
	word_t               b_q     [RS_DEPTH];
	phys_tag_t           ta_q    [RS_DEPTH];
	phys_tag_t           tb_q    [RS_DEPTH];
	phys_tag_t           dst_q   [RS_DEPTH];
	rob_idx_t            rob_q   [RS_DEPTH];
	logic [RS_DEPTH-1:0] can_issue;
	logic [RS_DEPTH-1:0] pick;		// one-hot, oldest ready slot
	logic [RS_DEPTH-1:0] load_mask;	// one-hot, lowest empty slot

	assign full      = &valid_q;
	assign load_mask = ~valid_q & (valid_q + 1'b1);	// isolate lowest zero

	//////////////////////////////////////////////////////////////////////
	// select
	always_comb begin
		can_issue = valid_q & a_rdy_q & b_rdy_q;
		for (int i = 0; i < RS_DEPTH; i++) begin
			pick[i] = can_issue[i] && !(|(can_issue & older_q[i]));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// control state
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid_q     <= '0;
			a_rdy_q     <= '0;
			b_rdy_q     <= '0;
			issue_valid <= 1'b0;
			for (int i = 0; i < RS_DEPTH; i++) older_q[i] <= '0;
		end else begin
			issue_valid <= |pick;
			for (int i = 0; i < RS_DEPTH; i++) begin
				older_q[i] <= older_q[i] & ~pick;	// issued slot leaves every age mask
				if (pick[i]) valid_q[i] <= 1'b0;
				if (cdb_valid && ta_q[i] == cdb_tag) a_rdy_q[i] <= 1'b1;	// wakeup
				if (cdb_valid && tb_q[i] == cdb_tag) b_rdy_q[i] <= 1'b1;
				if (load && load_mask[i]) begin
					valid_q[i] <= 1'b1;
					a_rdy_q[i] <= a_ready;
					b_rdy_q[i] <= b_ready;
					older_q[i] <= valid_q & ~pick;	// everyone still here is older
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// operand and issue payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (pick[i]) begin
				issue_op      <= op_q[i];
				issue_a       <= a_q[i];
				issue_b       <= b_q[i];
				issue_tag     <= dst_q[i];
				issue_rob_idx <= rob_q[i];
			end
			if (cdb_valid && !a_rdy_q[i] && ta_q[i] == cdb_tag) a_q[i] <= cdb_value;
			if (cdb_valid && !b_rdy_q[i] && tb_q[i] == cdb_tag) b_q[i] <= cdb_value;
			if (load && load_mask[i]) begin
				op_q[i]  <= op_in;
				a_q[i]   <= a_in;
				b_q[i]   <= b_in;
				ta_q[i]  <= tag_a;
				tb_q[i]  <= tag_b;
				dst_q[i] <= dest_tag;
				rob_q[i] <= rob_idx;
			end
		end
	end

	// dispatch_ready in the top level must already include the full flag
	assert property (@(posedge clock) disable iff (!rst_n) load |-> !full);

endmodule

`default_nettype wire

//--- rtl/phys_regfile.sv
//////////////////////////////////////////////////////////////////////
// physical register values with one ready bit per tag
// written from the cdb, read at dispatch with cdb bypass
//////////////////////////////////////////////////////////////////////
`default_nettype none

module phys_regfile import core_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  phys_tag_t tag_a,
	input  phys_tag_t tag_b,
	input  logic      alloc,		// new_tag becomes pending
	input  phys_tag_t new_tag,
	input  logic      cdb_valid,
	input  phys_tag_t cdb_tag,
	input  word_t     cdb_value,
	output word_t     value_a,
	output word_t     value_b,
	output logic      ready_a,
	output logic      ready_b
);

	word_t                value_q [PHYS_REGS];
	logic [PHYS_REGS-1:0] ready_q;
	logic                 hit_a;	// cdb writes the tag being read
	logic                 hit_b;

	assign hit_a = cdb_valid && (cdb_tag == tag_a);
	assign hit_b = cdb_valid && (cdb_tag == tag_b);

	// bypass so a dispatch in the broadcast cycle never misses the value
	assign value_a = hit_a ? cdb_value : value_q[tag_a];
	assign value_b = hit_b ? cdb_value : value_q[tag_b];
	assign ready_a = hit_a || ready_q[tag_a];
	assign ready_b = hit_b || ready_q[tag_b];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < PHYS_REGS; i++) begin
				value_q[i] <= '0;
				ready_q[i] <= (i < ARCH_REGS);	// arch regs start at zero and ready
			end
		end else begin
			if (alloc) begin
				ready_q[new_tag] <= 1'b0;	// producer now in flight
			end
			// a freshly allocated tag has no producer yet, so these never collide
			if (cdb_valid) begin
				value_q[cdb_tag] <= cdb_value;
				ready_q[cdb_tag] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rename_map.sv
//////////////////////////////////////////////////////////////////////
// register rename table plus the free list of physical tags
// alloc pops a tag and remaps dest, commit pushes the previous tag back
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rename_map import core_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      alloc,		// dispatch accepted this cycle
	input  arch_reg_t src_a,
	input  arch_reg_t src_b,
	input  arch_reg_t dest,
	input  logic      free_valid,	// commit pulse from the rob
	input  phys_tag_t free_tag,
	output phys_tag_t tag_a,
	output phys_tag_t tag_b,
	output phys_tag_t new_tag,
	output phys_tag_t old_tag,
	output logic      list_empty
);

	phys_tag_t map_q [ARCH_REGS];	// arch -> phys
	phys_tag_t fifo_q [PHYS_REGS];	// free tags, circular
	phys_tag_t head_q;				// pop slot, wraps at 16 on its own
	phys_tag_t tail_q;				// push slot
	logic [$clog2(PHYS_REGS):0] free_count_q;

	// lookups happen before this cycle's remap, so src == dest reads the old producer
	assign tag_a      = map_q[src_a];
	assign tag_b      = map_q[src_b];
	assign old_tag    = map_q[dest];
	assign new_tag    = fifo_q[head_q];
	assign list_empty = (free_count_q == '0);

	//////////////////////////////////////////////////////////////////////
	// map table and free list
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < ARCH_REGS; i++) begin
				map_q[i] <= phys_tag_t'(i);	// identity map out of reset
			end
			// slots 0..7 hold tags 8..15, upper slots are don't care
			for (int i = 0; i < PHYS_REGS; i++) begin
				fifo_q[i] <= phys_tag_t'(i + ARCH_REGS);
			end
			head_q       <= '0;
			tail_q       <= phys_tag_t'(PHYS_REGS - ARCH_REGS);
			free_count_q <= ($clog2(PHYS_REGS) + 1)'(PHYS_REGS - ARCH_REGS);
		end else begin
			if (alloc) begin
				map_q[dest] <= fifo_q[head_q];
				head_q      <= head_q + 1'b1;
			end
			if (free_valid) begin
				fifo_q[tail_q] <= free_tag;	// superseded mapping is dead now
				tail_q         <= tail_q + 1'b1;
			end
			case ({alloc, free_valid})
				2'b10:   free_count_q <= free_count_q - 1'b1;
				2'b01:   free_count_q <= free_count_q + 1'b1;
				default: free_count_q <= free_count_q;	// none, or pop and push
			endcase
		end
	end

	// the dispatch gate in the top level has to hold off when no tag is left
	assert property (@(posedge clock) disable iff (!rst_n) alloc |-> !list_empty);

endmodule

`default_nettype wire

//--- rtl/isa_pkg.sv
//////////////////////////////////////////////////////////////////////
// operation encoding seen at the dispatch port of the core
// ops arrive already decoded, so only the opcode and imm width live here
//////////////////////////////////////////////////////////////////////
`default_nettype none

package isa_pkg;

	localparam int IMM_W = 16;	// immediate width, same as a data word

	// alu function select
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,	// a + b
		OP_SUB = 3'd1,	// a - b
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_LI  = 3'd5	// load immediate, result is operand b
	} opcode_t;

endpackage

`default_nettype wire

//--- rtl/core_pkg.sv
//////////////////////////////////////////////////////////////////////
// sizes and index types shared by every storage structure of the core
// import with core_pkg::* in the module header
//////////////////////////////////////////////////////////////////////
`default_nettype none

package core_pkg;

	//////////////////////////////////////////////////////////////////////
	// storage sizes
	localparam int DATA_W    = 16;	// data word width
	localparam int ARCH_REGS = 8;	// architectural registers
	localparam int PHYS_REGS = 16;	// physical registers, arch + rename headroom
	localparam int ROB_DEPTH = 8;	// reorder buffer slots
	localparam int RS_DEPTH  = 4;	// reservation station slots

	//////////////////////////////////////////////////////////////////////
	// index and data types
	typedef logic [DATA_W-1:0]            word_t;
	typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;	// 3 bits
	typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;	// 4 bits
	typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;	// 3 bits

endpackage

`default_nettype wire
